/* hdl/mmu_pkg.sv */
// MMU shared widths, TLB entry field layouts and segment encoding
package mmu_pkg;

    localparam int VA_W   = 32;
    localparam int ASID_W = 8;
    localparam int MASK_W = 12;
    localparam int PFN_W  = 20;
    localparam int VPN2_W = 19;

    localparam logic [2:0] CACHE_CACHEABLE = 3'd3;

    typedef struct packed {
        logic [5:0]       zero;
        logic [PFN_W-1:0] pfn;
        logic [2:0]       c;
        logic             d;
        logic             v;
        logic             g;
    } entrylo_fields_t;

    // Raw word on the CP0 side, fields inside the TLB
    typedef union packed {
        logic [31:0]     raw;
        entrylo_fields_t f;
    } entrylo_u;

    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [4:0]        zero;
        logic [ASID_W-1:0] asid;
    } entryhi_fields_t;

    typedef union packed {
        logic [31:0]     raw;
        entryhi_fields_t f;
    } entryhi_u;

    typedef struct packed {
        logic [MASK_W-1:0] mask;
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        entrylo_fields_t   lo0;
        entrylo_fields_t   lo1;
    } tlb_entry_t;

    typedef enum logic [2:0] {
        useg,
        kseg0,
        kseg1,
        ksseg,
        kseg3
    } seg_e;

endpackage

/* hdl/tlb_lookup_if.sv */
// TLB lookup bundle carrying entry contents and mode context to the translator
`timescale 1ns/100ps

interface tlb_lookup_if import mmu_pkg::*; #(
    parameter int IDX_BITS = 3
);

    localparam int NUM_ENTRIES = 2 ** IDX_BITS;

    tlb_entry_t        entries [NUM_ENTRIES];
    logic [ASID_W-1:0] cur_asid;
    logic              kernel_mode;
    logic              erl;
    logic              kseg0_cached;

    modport array (
        output entries,
        output cur_asid,
        output kernel_mode,
        output erl,
        output kseg0_cached
    );

    modport xlat (
        input entries,
        input cur_asid,
        input kernel_mode,
        input erl,
        input kseg0_cached
    );

endinterface

/* hdl/tlb_entry_array.sv */
// Joint TLB entry storage with indexed write, indexed read and probe
`timescale 1ns/100ps

module tlb_entry_array import mmu_pkg::*; #(
    parameter int IDX_BITS = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                we_i,
    input  logic [IDX_BITS-1:0] index_i,
    input  logic [MASK_W-1:0]   mask_i,
    input  entryhi_u            entryhi_i,
    input  entrylo_u            entrylo0_i,
    input  entrylo_u            entrylo1_i,
    output logic [MASK_W-1:0]   mask_o,
    output entryhi_u            entryhi_o,
    output entrylo_u            entrylo0_o,
    output entrylo_u            entrylo1_o,
    output logic [31:0]         probe_index_o,
    input  logic                kernel_mode_i,
    input  logic                erl_i,
    input  logic                kseg0_cached_i,
    tlb_lookup_if.array         lk
);

    localparam int NUM_ENTRIES = 2 ** IDX_BITS;

    tlb_entry_t entries_q [NUM_ENTRIES];
    tlb_entry_t wr_entry;
    tlb_entry_t rd_entry;

    logic [VPN2_W-1:0]      wr_vpn_keep;
    logic [PFN_W-1:0]       wr_pfn_keep;
    logic [NUM_ENTRIES-1:0] probe_match;
    logic [IDX_BITS-1:0]    probe_idx;

    assign wr_vpn_keep = ~{{(VPN2_W - MASK_W){1'b0}}, mask_i};
    assign wr_pfn_keep = ~{{(PFN_W - MASK_W){1'b0}}, mask_i};

    // Page bits under the mask are dropped when the entry is written
    always_comb begin
        wr_entry      = '0;
        wr_entry.mask = mask_i;
        wr_entry.vpn2 = entryhi_i.f.vpn2 & wr_vpn_keep;
        wr_entry.asid = entryhi_i.f.asid;
        wr_entry.g    = entrylo0_i.f.g & entrylo1_i.f.g;

        wr_entry.lo0.pfn = entrylo0_i.f.pfn & wr_pfn_keep;
        wr_entry.lo0.c   = entrylo0_i.f.c;
        wr_entry.lo0.d   = entrylo0_i.f.d;
        wr_entry.lo0.v   = entrylo0_i.f.v;
        wr_entry.lo0.g   = wr_entry.g;

        wr_entry.lo1.pfn = entrylo1_i.f.pfn & wr_pfn_keep;
        wr_entry.lo1.c   = entrylo1_i.f.c;
        wr_entry.lo1.d   = entrylo1_i.f.d;
        wr_entry.lo1.v   = entrylo1_i.f.v;
        wr_entry.lo1.g   = wr_entry.g;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < NUM_ENTRIES; n++) begin
                entries_q[n]       <= '0;
                entries_q[n].lo0.c <= CACHE_CACHEABLE;
                entries_q[n].lo1.c <= CACHE_CACHEABLE;
            end
        end else if (we_i) begin
            entries_q[index_i] <= wr_entry;
        end
    end

    // TLBR view
    always_comb begin
        rd_entry              = entries_q[index_i];
        mask_o                = rd_entry.mask;
        entryhi_o.f.vpn2      = rd_entry.vpn2;
        entryhi_o.f.zero      = '0;
        entryhi_o.f.asid      = rd_entry.asid;
        entrylo0_o.f          = rd_entry.lo0;
        entrylo1_o.f          = rd_entry.lo1;
    end

    // TLBP compare against every entry
    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_probe
        logic [VPN2_W-1:0] vpn_keep;

        assign vpn_keep = ~{{(VPN2_W - MASK_W){1'b0}}, entries_q[i].mask};
        assign probe_match[i] =
            ((entryhi_i.f.vpn2 & vpn_keep) == (entries_q[i].vpn2 & vpn_keep)) &&
            (entries_q[i].g || entries_q[i].asid == entryhi_i.f.asid);
    end

    always_comb begin
        probe_idx = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (probe_match[i]) begin
                probe_idx = probe_idx | IDX_BITS'(i);
            end
        end
    end

    assign probe_index_o = {~|probe_match, {(31 - IDX_BITS){1'b0}}, probe_idx};

    assign lk.entries      = entries_q;
    assign lk.cur_asid     = entryhi_i.f.asid;
    assign lk.kernel_mode  = kernel_mode_i;
    assign lk.erl          = erl_i;
    assign lk.kseg0_cached = kseg0_cached_i;

endmodule

/* hdl/xlat_req_stage.sv */
// Translation request producer gated by queue credits
`timescale 1ns/100ps

module xlat_req_stage import mmu_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid_i,
    input  logic [VA_W-1:0] req_va_i,
    output logic            req_ready_o,
    input  logic            credit_i,
    output logic            push_o,
    output logic [VA_W-1:0] push_va_o
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [CNT_W-1:0] credits_q;

    assign req_ready_o = credits_q != '0;
    assign push_o      = req_valid_i && req_ready_o;
    assign push_va_o   = req_va_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits_q <= CNT_W'(FIFO_DEPTH);
        end else begin
            case ({push_o, credit_i})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

endmodule

/* hdl/xlat_req_fifo.sv */
// Request queue for virtual addresses, one credit returned per pop
`timescale 1ns/100ps

module xlat_req_fifo import mmu_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            push_i,
    input  logic [VA_W-1:0] push_va_i,
    input  logic            pop_i,
    output logic            not_empty_o,
    output logic [VA_W-1:0] head_va_o,
    output logic            credit_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(FIFO_DEPTH - 1);

    logic [VA_W-1:0]  mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    assign not_empty_o = count_q != '0;
    assign head_va_o   = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_va_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            credit_o <= pop_i;
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* hdl/addr_translator.sv */
// Address translator with segment decode, TLB match and registered response
`timescale 1ns/100ps

module addr_translator import mmu_pkg::*; #(
    parameter int IDX_BITS = 3
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            not_empty_i,
    input  logic [VA_W-1:0] head_va_i,
    output logic            pop_o,
    tlb_lookup_if.xlat      lk,
    input  logic            resp_ready_i,
    output logic            resp_valid_o,
    output logic [VA_W-1:0] pa_o,
    output logic            hit_o,
    output logic            valid_o,
    output logic            dirty_o,
    output logic            cached_o,
    output logic            addr_err_o
);

    localparam int NUM_ENTRIES = 2 ** IDX_BITS;
    localparam int OFS_W       = VA_W - VPN2_W - 1;

    seg_e            seg;
    logic            mapped;
    logic            addr_err;
    logic [NUM_ENTRIES-1:0] match;
    entrylo_fields_t page [NUM_ENTRIES];
    logic [VA_W-1:0] page_pa [NUM_ENTRIES];
    logic [VA_W-1:0] tlb_pa;
    logic [2:0]      tlb_c;
    logic            tlb_v;
    logic            tlb_d;

    always_comb begin
        case (head_va_i[VA_W-1 -: 3])
            3'b100:  seg = kseg0;
            3'b101:  seg = kseg1;
            3'b110:  seg = ksseg;
            3'b111:  seg = kseg3;
            default: seg = useg;
        endcase
    end

    // Kernel sees everything; with erl set useg is unmapped
    always_comb begin
        mapped   = 1'b0;
        addr_err = 1'b0;
        case (seg)
            useg:         mapped = !(lk.kernel_mode && lk.erl);
            kseg0, kseg1: addr_err = !lk.kernel_mode;
            default: begin
                mapped   = lk.kernel_mode;
                addr_err = !lk.kernel_mode;
            end
        endcase
    end

    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_match
        logic [VPN2_W-1:0] vpn_keep;
        logic [MASK_W:0]   odd_sel;

        assign vpn_keep = ~{{(VPN2_W - MASK_W){1'b0}}, lk.entries[i].mask};
        assign match[i] =
            ((head_va_i[VA_W-1 -: VPN2_W] & vpn_keep) == (lk.entries[i].vpn2 & vpn_keep)) &&
            (lk.entries[i].g || lk.entries[i].asid == lk.cur_asid);

        // One-hot on the bit just above the masked offset
        assign odd_sel = {lk.entries[i].mask, 1'b1} ^ {1'b0, lk.entries[i].mask};
        assign page[i] = |(head_va_i[OFS_W +: MASK_W + 1] & odd_sel) ?
                         lk.entries[i].lo1 : lk.entries[i].lo0;
        assign page_pa[i] = {page[i].pfn, {OFS_W{1'b0}}} |
            (head_va_i & {{(VA_W - MASK_W - OFS_W){1'b0}}, lk.entries[i].mask, {OFS_W{1'b1}}});
    end

    always_comb begin
        tlb_pa = '0;
        tlb_c  = '0;
        tlb_v  = 1'b0;
        tlb_d  = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (match[i]) begin
                tlb_pa = tlb_pa | page_pa[i];
                tlb_c  = tlb_c | page[i].c;
                tlb_v  = tlb_v | page[i].v;
                tlb_d  = tlb_d | page[i].d;
            end
        end
    end

    assign pop_o = not_empty_i && (!resp_valid_o || resp_ready_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid_o <= 1'b0;
        end else if (pop_o) begin
            resp_valid_o <= 1'b1;
        end else if (resp_ready_i) begin
            resp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            addr_err_o <= addr_err;
            if (mapped) begin
                pa_o     <= tlb_pa;
                hit_o    <= |match;
                valid_o  <= tlb_v;
                dirty_o  <= tlb_d;
                cached_o <= tlb_c == CACHE_CACHEABLE;
            end else begin
                pa_o     <= {3'b000, head_va_i[VA_W-4:0]};
                hit_o    <= 1'b1;
                valid_o  <= 1'b1;
                dirty_o  <= 1'b1;
                cached_o <= (seg == kseg0) && lk.kseg0_cached;
            end
        end
    end

endmodule

/* hdl/mmu_top.sv */
// MMU top joining the TLB array, request queue and translator
`timescale 1ns/100ps

module mmu_top import mmu_pkg::*; #(
    parameter int IDX_BITS   = 3,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                we_i,
    input  logic [IDX_BITS-1:0] index_i,
    input  logic [MASK_W-1:0]   mask_i,
    input  logic [31:0]         entryhi_i,
    input  logic [31:0]         entrylo0_i,
    input  logic [31:0]         entrylo1_i,
    output logic [MASK_W-1:0]   mask_o,
    output logic [31:0]         entryhi_o,
    output logic [31:0]         entrylo0_o,
    output logic [31:0]         entrylo1_o,
    output logic [31:0]         probe_index_o,
    input  logic                kernel_mode_i,
    input  logic                erl_i,
    input  logic                kseg0_cached_i,
    input  logic                req_valid_i,
    input  logic [VA_W-1:0]     req_va_i,
    output logic                req_ready_o,
    input  logic                resp_ready_i,
    output logic                resp_valid_o,
    output logic [VA_W-1:0]     pa_o,
    output logic                hit_o,
    output logic                valid_o,
    output logic                dirty_o,
    output logic                cached_o,
    output logic                addr_err_o
);

    logic            push;
    logic [VA_W-1:0] push_va;
    logic            credit;
    logic            not_empty;
    logic [VA_W-1:0] head_va;
    logic            pop;

    tlb_lookup_if #(.IDX_BITS(IDX_BITS)) lk ();

    tlb_entry_array #(.IDX_BITS(IDX_BITS)) u_array (
        .clk            (clk),
        .rst            (rst),
        .we_i           (we_i),
        .index_i        (index_i),
        .mask_i         (mask_i),
        .entryhi_i      (entryhi_i),
        .entrylo0_i     (entrylo0_i),
        .entrylo1_i     (entrylo1_i),
        .mask_o         (mask_o),
        .entryhi_o      (entryhi_o),
        .entrylo0_o     (entrylo0_o),
        .entrylo1_o     (entrylo1_o),
        .probe_index_o  (probe_index_o),
        .kernel_mode_i  (kernel_mode_i),
        .erl_i          (erl_i),
        .kseg0_cached_i (kseg0_cached_i),
        .lk             (lk.array)
    );

    xlat_req_stage #(.FIFO_DEPTH(FIFO_DEPTH)) u_req_stage (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_va_i    (req_va_i),
        .req_ready_o (req_ready_o),
        .credit_i    (credit),
        .push_o      (push),
        .push_va_o   (push_va)
    );

    xlat_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_req_fifo (
        .clk         (clk),
        .rst         (rst),
        .push_i      (push),
        .push_va_i   (push_va),
        .pop_i       (pop),
        .not_empty_o (not_empty),
        .head_va_o   (head_va),
        .credit_o    (credit)
    );

    addr_translator #(.IDX_BITS(IDX_BITS)) u_translator (
        .clk          (clk),
        .rst          (rst),
        .not_empty_i  (not_empty),
        .head_va_i    (head_va),
        .pop_o        (pop),
        .lk           (lk.xlat),
        .resp_ready_i (resp_ready_i),
        .resp_valid_o (resp_valid_o),
        .pa_o         (pa_o),
        .hit_o        (hit_o),
        .valid_o      (valid_o),
        .dirty_o      (dirty_o),
        .cached_o     (cached_o),
        .addr_err_o   (addr_err_o)
    );

endmodule

/* test/mmu_ref.svh */
// MMU reference model for segment rules, TLB match, page select and probe
`ifndef MMU_REF_SVH
`define MMU_REF_SVH

// Result layout {addr_err, pa, hit, valid, dirty, cached}
function automatic logic [36:0] ref_translate(input logic [31:0] va, input logic kernel,
                                              input logic erl, input logic k0_cached,
                                              input logic [7:0] asid);
    logic [2:0]  top;
    logic [18:0] keep;
    logic [31:0] lo;
    logic [31:0] ofs_mask;
    int          ofs_w;
    top = va[31:29];
    if (!kernel && top[2]) begin
        return {1'b1, 36'b0};
    end
    if (top == 3'b100 || top == 3'b101 || (!top[2] && kernel && erl)) begin
        return {1'b0, 3'b000, va[28:0], 3'b111, top == 3'b100 && k0_cached};
    end
    for (int i = 0; i < N_ENT; i++) begin
        keep = ~{7'b0, r_mask[i]};
        if ((va[31:13] & keep) == (r_hi[i][31:13] & keep) &&
            (r_lo0[i][0] || r_hi[i][7:0] == asid)) begin
            ofs_w = 12;
            for (int b = 0; b < 12; b++) begin
                if (r_mask[i][b]) begin
                    ofs_w++;
                end
            end
            // Odd page when the bit above the offset is set
            lo       = va[ofs_w] ? r_lo1[i] : r_lo0[i];
            ofs_mask = (32'd1 << ofs_w) - 32'd1;
            return {1'b0, {lo[25:6], 12'b0} | (va & ofs_mask), 1'b1, lo[1], lo[2],
                    lo[5:3] == 3'd3};
        end
    end
    return '0;
endfunction

function automatic logic [31:0] ref_probe(input logic [31:0] hi);
    logic [18:0] keep;
    for (int i = 0; i < N_ENT; i++) begin
        keep = ~{7'b0, r_mask[i]};
        if ((hi[31:13] & keep) == (r_hi[i][31:13] & keep) &&
            (r_lo0[i][0] || r_hi[i][7:0] == hi[7:0])) begin
            return 32'(i);
        end
    end
    return 32'h8000_0000;
endfunction

`endif

/* test/mmu_tb.sv */
// MMU testbench with TLB write, read, probe and translation stream checks
`timescale 1ns/100ps

module mmu_tb import mmu_pkg::*; ();

    localparam int IDX_BITS     = 3;
    localparam int FIFO_DEPTH   = 4;
    localparam int N_ENT        = 2 ** IDX_BITS;
    localparam int CLK_PERIOD   = 20;
    localparam int N_RAND       = 200;
    localparam int N_DIRECTED   = 64;
    localparam int STALL_CYCLES = 40;
    localparam int SETUP_CYCLES = 400;
    localparam int TIMEOUT_NS   =
        ((N_RAND + N_DIRECTED + FIFO_DEPTH + 1) * STALL_CYCLES + SETUP_CYCLES) * CLK_PERIOD;

    logic                clk;
    logic                rst;
    logic                we_i;
    logic [IDX_BITS-1:0] index_i;
    logic [MASK_W-1:0]   mask_i;
    logic [31:0]         entryhi_i;
    logic [31:0]         entrylo0_i;
    logic [31:0]         entrylo1_i;
    logic [MASK_W-1:0]   mask_o;
    logic [31:0]         entryhi_o;
    logic [31:0]         entrylo0_o;
    logic [31:0]         entrylo1_o;
    logic [31:0]         probe_index_o;
    logic                kernel_mode_i;
    logic                erl_i;
    logic                kseg0_cached_i;
    logic                req_valid_i;
    logic [VA_W-1:0]     req_va_i;
    logic                req_ready_o;
    logic                resp_ready_i;
    logic                resp_valid_o;
    logic [VA_W-1:0]     pa_o;
    logic                hit_o;
    logic                valid_o;
    logic                dirty_o;
    logic                cached_o;
    logic                addr_err_o;

    // Testbench copy of the stored entries
    logic [11:0] r_mask [N_ENT];
    logic [31:0] r_hi   [N_ENT];
    logic [31:0] r_lo0  [N_ENT];
    logic [31:0] r_lo1  [N_ENT];

    logic [36:0] exp_q [$];
    logic [36:0] exp_res;
    logic [15:0] addr_lfsr;
    logic [15:0] rdy_lfsr;
    logic [1:0]  rdy_mode;
    int          checks;
    int          errors;

    `include "mmu_ref.svh"

    mmu_top #(.IDX_BITS(IDX_BITS), .FIFO_DEPTH(FIFO_DEPTH)) dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            addr_lfsr = lfsr_step(addr_lfsr);
            v = {v[30:0], addr_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [11:0] entry_mask(input int i);
        case (i % 5)
            0:       return 12'h000;
            1:       return 12'h003;
            2:       return 12'h00F;
            3:       return 12'h03F;
            default: return 12'hFFF;
        endcase
    endfunction

    // Entry 7 sits in kseg3, the rest spread over useg
    function automatic logic [18:0] entry_vpn2(input int i);
        return (i == 7) ? 19'h70000 : 19'(i + 1) << 12;
    endfunction

    function automatic logic [7:0] entry_asid(input int i);
        case (i)
            1, 3:    return 8'h21;
            5, 6:    return 8'h44;
            default: return 8'h5A;
        endcase
    endfunction

    function automatic logic [31:0] odd_bit(input logic [11:0] mask);
        return 32'({mask, 12'hFFF}) + 32'd1;
    endfunction

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_entry(input int idx, input logic [11:0] mask, input logic [31:0] hi,
                               input logic [31:0] lo0, input logic [31:0] lo1);
        logic [18:0] vkeep;
        logic [19:0] pkeep;
        logic        g;
        vkeep      = ~{7'b0, mask};
        pkeep      = ~{8'b0, mask};
        g          = lo0[0] & lo1[0];
        we_i       = 1'b1;
        index_i    = IDX_BITS'(idx);
        mask_i     = mask;
        entryhi_i  = hi;
        entrylo0_i = lo0;
        entrylo1_i = lo1;
        @(negedge clk);
        we_i       = 1'b0;
        r_mask[idx] = mask;
        r_hi[idx]   = {hi[31:13] & vkeep, 5'b0, hi[7:0]};
        r_lo0[idx]  = {6'b0, lo0[25:6] & pkeep, lo0[5:1], g};
        r_lo1[idx]  = {6'b0, lo1[25:6] & pkeep, lo1[5:1], g};
    endtask

    task automatic send_req(input logic [31:0] va);
        req_valid_i = 1'b1;
        req_va_i    = va;
        while (!req_ready_o) begin
            @(negedge clk);
        end
        exp_q.push_back(ref_translate(va, kernel_mode_i, erl_i, kseg0_cached_i,
                                      entryhi_i[7:0]));
        @(negedge clk);
    endtask

    task automatic drain_resp();
        req_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Mode changes land between edges so the ready process sees them cleanly
    task automatic set_ready_mode(input logic [1:0] m);
        @(posedge clk);
        rdy_mode = m;
        @(negedge clk);
    endtask

    always @(negedge clk) begin
        case (rdy_mode)
            2'd0: resp_ready_i = 1'b1;
            2'd1: begin
                rdy_lfsr     = lfsr_step(rdy_lfsr);
                resp_ready_i = rdy_lfsr[0];
            end
            default: resp_ready_i = 1'b0;
        endcase
    end

    // Response compare in request order
    always @(posedge clk) begin
        if (!rst && resp_valid_o && resp_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected response at %0t ns with no request outstanding", $time);
            end else begin
                exp_res = exp_q.pop_front();
                check_val("addr_err", addr_err_o, exp_res[36]);
                if (!exp_res[36]) begin
                    check_val("pa", pa_o, exp_res[35:4]);
                    check_val("hit", hit_o, exp_res[3]);
                    check_val("valid", valid_o, exp_res[2]);
                    check_val("dirty", dirty_o, exp_res[1]);
                    check_val("cached", cached_o, exp_res[0]);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not complete within %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [19:0] pfn;
        logic [31:0] base;
        logic [31:0] va;
        int          idx;
        int          accepted;
        int          quiet;
        clk            = 1'b0;
        rst            = 1'b1;
        we_i           = 1'b0;
        index_i        = '0;
        mask_i         = '0;
        entryhi_i      = '0;
        entrylo0_i     = '0;
        entrylo1_i     = '0;
        kernel_mode_i  = 1'b1;
        erl_i          = 1'b0;
        kseg0_cached_i = 1'b1;
        req_valid_i    = 1'b0;
        req_va_i       = '0;
        resp_ready_i   = 1'b1;
        rdy_mode       = 2'd0;
        addr_lfsr      = 16'd55;
        rdy_lfsr       = 16'd55;
        checks         = 0;
        errors         = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // Fill every entry; junk below the mask must be dropped
        for (int i = 0; i < N_ENT; i++) begin
            pfn = 20'hFFFFF ^ (20'(i) * 20'h01357);
            write_entry(i, entry_mask(i),
                {entry_vpn2(i) | 19'(entry_mask(i)), 5'b0, entry_asid(i)},
                {6'b0, pfn, (i[0] ? 3'd3 : 3'd2), i[1], 1'b1, i != 1 && i != 3 && i != 6},
                {6'b0, pfn ^ 20'h80A5A, (i[1] ? 3'd3 : 3'd0), !i[1], i != 6,
                 i == 0 || i == 2 || i == 4 || i == 7});
        end

        for (int i = 0; i < N_ENT; i++) begin
            index_i = IDX_BITS'(i);
            @(posedge clk);
            check_val("read mask", mask_o, r_mask[i]);
            check_val("read entryhi", entryhi_o, r_hi[i]);
            check_val("read entrylo0", entrylo0_o, r_lo0[i]);
            check_val("read entrylo1", entrylo1_o, r_lo1[i]);
            @(negedge clk);
        end

        for (int i = 0; i < N_ENT; i++) begin
            entryhi_i = r_hi[i] | {7'b0, r_mask[i], 13'b0};
            @(posedge clk);
            check_val("probe index", probe_index_o, ref_probe(entryhi_i));
            @(negedge clk);
        end
        entryhi_i = {19'h7FFFF, 5'b0, 8'h21};
        @(posedge clk);
        check_val("probe miss flag", probe_index_o[31], 1'b1);
        check_val("probe miss", probe_index_o, ref_probe(entryhi_i));
        @(negedge clk);
        entryhi_i = 32'h0000_0021;

        // Unmapped kernel segments under both cache settings
        for (int k = 0; k < 2; k++) begin
            kseg0_cached_i = k[0];
            send_req(32'h8000_1234);
            send_req(32'h9FFF_FFF0);
            send_req(32'hA000_0040);
            send_req(32'hBFC0_0000);
            drain_resp();
        end
        erl_i = 1'b1;
        send_req(32'h0040_0000);
        drain_resp();
        erl_i = 1'b0;

        for (int i = 0; i < N_ENT; i++) begin
            base = {entry_vpn2(i), 13'b0};
            send_req(base | 32'h123);
            send_req(base | odd_bit(r_mask[i]) | 32'h456);
        end
        send_req(32'h7FFF_E000);
        send_req(32'h4000_0010);
        drain_resp();
        entryhi_i = 32'h0000_0044;
        for (int i = 5; i < 7; i++) begin
            base = {entry_vpn2(i), 13'b0};
            send_req(base | 32'h0F8);
            send_req(base | odd_bit(r_mask[i]) | 32'h0F8);
        end
        drain_resp();
        entryhi_i = 32'h0000_0021;

        kernel_mode_i = 1'b0;
        send_req(32'h8000_0010);
        send_req(32'hA000_0020);
        send_req(32'hC000_0030);
        send_req(32'hE000_0100);
        send_req({entry_vpn2(1), 13'b0} | 32'h10);
        send_req({entry_vpn2(3), 13'b0} | odd_bit(r_mask[3]));
        drain_resp();
        kernel_mode_i = 1'b1;

        // Full stall: queue plus output register absorb the requests
        set_ready_mode(2'd2);
        accepted = 0;
        quiet    = 0;
        while (quiet < 4) begin
            if (req_ready_o) begin
                va          = rand_bits(32);
                req_valid_i = 1'b1;
                req_va_i    = va;
                exp_q.push_back(ref_translate(va, kernel_mode_i, erl_i, kseg0_cached_i,
                                              entryhi_i[7:0]));
                accepted++;
                quiet = 0;
            end else begin
                req_valid_i = 1'b0;
                quiet++;
            end
            @(negedge clk);
        end
        req_valid_i = 1'b0;
        check_val("accepted during stall", accepted, FIFO_DEPTH + 1);

        set_ready_mode(2'd1);
        for (int n = 0; n < N_RAND; n++) begin
            if (rand_bits(1) == 32'd1) begin
                idx = int'(rand_bits(3));
                va  = {entry_vpn2(idx), 13'b0} | (rand_bits(32) & 32'({r_mask[idx], 13'h1FFF}));
            end else begin
                va = rand_bits(32);
            end
            send_req(va);
        end
        drain_resp();
        set_ready_mode(2'd0);
        repeat (10) @(negedge clk);

        $display("Run finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+test
hdl/mmu_pkg.sv
hdl/tlb_lookup_if.sv
hdl/tlb_entry_array.sv
hdl/xlat_req_stage.sv
hdl/xlat_req_fifo.sv
hdl/addr_translator.sv
hdl/mmu_top.sv
test/mmu_tb.sv

/* Makefile */
# Verilator build and run for the MMU testbench

VERILATOR ?= verilator
TOP       ?= mmu_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -x '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
